//--- compile.f
logic/hawk_pkg.sv
logic/hawk_pgwr_mngr.sv
logic/hawk_pgrd_mngr.sv
logic/hawk_wb_arb.sv
logic/hawk_core.sv
sim/hawk_clkgen.sv
sim/hawk_mem_model.sv
sim/hawk_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= hawk_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- sim/hawk_tb.sv
`timescale 1ns/10ps

module hawk_tb import hawk_pkg::*; ();

   logic              clk_i;
   logic              reset;
   wb_req_t           cpu_req;
   wb_rsp_t           cpu_rsp;
   wb_req_t           mem_req;
   wb_rsp_t           mem_rsp;
   att_upd_t          att_upd;
   logic              upd_busy;
   logic [PPAGE_W-1:0] shadow [ATT_ENTRIES];
   logic [ADDR_W-1:0] wa [20];
   logic [DATA_W-1:0] wd [20];
   logic [DATA_W-1:0] exp_rdata;
   logic [DATA_W-1:0] rnd;
   logic              rst_seen = 1'b0;
   int                init_cnt;
   int                cycles = 0;
   int                seed;
   string             test_name;
   logic              txn;
   logic [VPAGE_W-1:0] cv;
   logic [OFFS_W-1:0] co;
   logic [DATA_W-1:0] backdoor_dat;
   logic [63:0]       init_exp;
   logic [63:0]       init_act;
   logic [63:0]       lkup_exp;
   logic [63:0]       lkup_act;
   logic [63:0]       acc_exp;
   logic [63:0]       acc_act;

   hawk_clkgen clkgen_i (.clk_i(clk_i), .reset(reset));

   hawk_core dut_i (
      .clk_i    (clk_i),
      .reset    (reset),
      .cpu_req  (cpu_req),
      .cpu_rsp  (cpu_rsp),
      .mem_req  (mem_req),
      .mem_rsp  (mem_rsp),
      .att_upd  (att_upd),
      .upd_busy (upd_busy)
   );

   hawk_mem_model mem_i (.clk_i(clk_i), .reset(reset), .req(mem_req), .rsp(mem_rsp));

   assign cv           = cpu_req.adr[OFFS_W +: VPAGE_W];
   assign co           = cpu_req.adr[OFFS_W-1:0];
   assign txn          = mem_req.cyc && mem_req.stb && mem_rsp.ack;
   assign backdoor_dat = mem_i.mem[{shadow[cv], co}];

   // expected and seen fields, packed to 64 bits for the error line
   assign init_exp = {15'h0, 1'b1, ATT_BASE + ADDR_W'(init_cnt), 20'h0,
                      DATA_BASE_PAGE + PPAGE_W'(init_cnt)};
   assign init_act = {15'h0, mem_req.we, mem_req.adr, mem_req.dat};
   assign lkup_exp = {36'h0, ATT_BASE + ADDR_W'(cv), shadow[cv]};
   assign lkup_act = {36'h0, mem_req.adr, mem_rsp.dat[PPAGE_W-1:0]};
   assign acc_exp  = {11'h0, cpu_req.we, shadow[cv], co, cpu_req.dat, cpu_req.sel};
   assign acc_act  = {11'h0, mem_req.we, mem_req.adr, mem_req.dat, mem_req.sel};

   task automatic value_fail(input string name, input logic [63:0] expv, input logic [63:0] actv);
      $display("FAIL %s expected %h actual %h", name, expv, actv);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic event_fail(input string what);
      $display("%s during %s", what, test_name);
      $display("CHECKS FAILED");
      $fatal(1, "protocol error");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // shadow att, init write count and run limit
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk_i) begin
      cycles   <= cycles + 1;
      rst_seen <= reset;
      if (cycles >= 2000) begin
         $display("timeout after %0d cycles in %s", cycles, test_name);
         $display("CHECKS FAILED");
         $fatal(1, "timeout");
      end
      if (reset) begin
         init_cnt <= 0;
         for (int i = 0; i < ATT_ENTRIES; i++)
            shadow[i] <= DATA_BASE_PAGE + PPAGE_W'(i);
      end else begin
         if (txn && init_cnt < ATT_ENTRIES)
            init_cnt <= init_cnt + 1;
         if (att_upd.valid && !upd_busy)
            shadow[att_upd.vpage] <= att_upd.ppage;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   reset_vals: assert property (@(posedge clk_i) (reset && rst_seen) |->
         (!cpu_rsp.ack && !mem_req.cyc && !mem_req.stb && upd_busy && !dut_i.init_done))
      else event_fail("outputs not at reset values");

   init_write: assert property (@(posedge clk_i) disable iff (reset)
         (txn && init_cnt < ATT_ENTRIES) |-> (init_act == init_exp))
      else value_fail("init_write", $sampled(init_exp), $sampled(init_act));

   early_ack: assert property (@(posedge clk_i) disable iff (reset)
         cpu_rsp.ack |-> (init_cnt == ATT_ENTRIES))
      else event_fail("cpu ack before att init finished");

   // lookup reads sit below the data pages
   lookup: assert property (@(posedge clk_i) disable iff (reset)
         (txn && !mem_req.we && mem_req.adr < 16'h0100) |-> (lkup_act == lkup_exp))
      else value_fail(test_name, $sampled(lkup_exp), $sampled(lkup_act));

   translate: assert property (@(posedge clk_i) disable iff (reset)
         (txn && mem_req.adr >= 16'h0100) |-> (acc_act == acc_exp))
      else value_fail(test_name, $sampled(acc_exp), $sampled(acc_act));

   rd_data: assert property (@(posedge clk_i) disable iff (reset)
         (cpu_rsp.ack && !cpu_req.we) |-> (cpu_rsp.dat == exp_rdata))
      else value_fail(test_name, {32'h0, $sampled(exp_rdata)}, {32'h0, $sampled(cpu_rsp.dat)});

   rd_backdoor: assert property (@(posedge clk_i) disable iff (reset)
         (cpu_rsp.ack && !cpu_req.we) |-> (cpu_rsp.dat == backdoor_dat))
      else value_fail(test_name, {32'h0, $sampled(backdoor_dat)},
         {32'h0, $sampled(cpu_rsp.dat)});

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   // one classic cycle with an optional att update in its first cycle
   task automatic cpu_access(input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                             input att_upd_t upd);
      @(posedge clk_i);
      #10;
      cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
      att_upd = upd;
      @(posedge clk_i);
      while (!cpu_rsp.ack) begin
         #10 att_upd = '0;
         @(posedge clk_i);
      end
      #10;
      cpu_req = '0;
      att_upd = '0;
   endtask

   task automatic cpu_read(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] expv);
      exp_rdata = expv;
      cpu_access(1'b0, adr, '0, 4'hf, '0);
   endtask

   task automatic remap(input logic [VPAGE_W-1:0] vpage, input logic [PPAGE_W-1:0] ppage);
      while (upd_busy)
         @(posedge clk_i);
      #10 att_upd = '{valid: 1'b1, vpage: vpage, ppage: ppage};
      @(posedge clk_i);
      #10 att_upd = '0;
      do
         @(posedge clk_i);
      while (upd_busy);
   endtask

   initial begin
      seed      = 58;
      cpu_req   = '0;
      att_upd   = '0;
      exp_rdata = '0;
      test_name = "reset";
      wait (!reset);

      // issued during init and held off until the att is filled
      test_name = "init";
      cpu_access(1'b1, 16'h0000, 32'h1234_5678, 4'hf, '0);

      test_name = "write_read";
      for (int i = 0; i < 20; i++) begin
         rnd   = $random(seed);
         wa[i] = {8'h00, i[3:0], rnd[2:0], i[4]};
         wd[i] = $random(seed);
         cpu_access(1'b1, wa[i], wd[i], 4'hf, '0);
      end
      for (int i = 0; i < 20; i++)
         cpu_read(wa[i], wd[i]);

      // vpage 3 moved onto the default page of vpage 7
      test_name = "remap";
      cpu_access(1'b1, 16'h0035, 32'hdead_0003, 4'hf, '0);
      cpu_access(1'b1, 16'h0075, 32'hbeef_0007, 4'hf, '0);
      remap(4'd3, DATA_BASE_PAGE + 12'd7);
      cpu_read(16'h0035, 32'hbeef_0007);

      test_name = "contention";
      cpu_access(1'b1, 16'h0021, 32'hcafe_f00d, 4'hf, '{valid: 1'b1, vpage: 4'd2, ppage: 12'h0a0});
      cpu_read(16'h0021, 32'hcafe_f00d);

      test_name = "byte_sel";
      cpu_access(1'b1, 16'h0021, 32'h1122_3344, 4'b0101, '0);
      cpu_read(16'h0021, 32'hca22_f044);

      @(posedge clk_i);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- sim/hawk_mem_model.sv
`timescale 1ns/10ps

module hawk_mem_model import hawk_pkg::*; (
   input  logic    clk_i,
   input  logic    reset,
   input  wb_req_t req,
   output wb_rsp_t rsp
);

   logic [DATA_W-1:0] mem [1 << ADDR_W];

   // fill from the full word address, so stale reads show up
   initial begin
      for (int i = 0; i < (1 << ADDR_W); i++)
         mem[i] = {~16'(i), 16'(i)};
   end

   // ack one cycle after stb, dropped again the cycle after
   always @(posedge clk_i) begin
      if (reset)
         rsp.ack <= 1'b0;
      else
         rsp.ack <= req.cyc && req.stb && !rsp.ack;
   end

   // byte lanes written only where sel is set
   always @(posedge clk_i) begin
      if (!reset && req.cyc && req.stb && !rsp.ack) begin
         rsp.dat <= mem[req.adr];
         if (req.we) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (req.sel[b])
                  mem[req.adr][8*b +: 8] <= req.dat[8*b +: 8];
            end
         end
      end
   end

endmodule

//--- sim/hawk_clkgen.sv
`timescale 1ns/10ps

module hawk_clkgen (
   output logic clk_i,
   output logic reset
);

   // 100 ns period, first rising edge at 50 ns
   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk_i);
      #10 reset = 1'b0;
   end

endmodule

//--- logic/hawk_core.sv
`timescale 1ns/10ps

module hawk_core import hawk_pkg::*; (
   input  logic     clk_i,
   input  logic     reset,
   input  wb_req_t  cpu_req,
   output wb_rsp_t  cpu_rsp,
   output wb_req_t  mem_req,
   input  wb_rsp_t  mem_rsp,
   input  att_upd_t att_upd,
   output logic     upd_busy
);

   // page writer side
   wb_req_t wr_req;
   wb_rsp_t wr_rsp;
   logic    init_done;

   // page reader side
   wb_req_t rd_req;
   wb_rsp_t rd_rsp;

   hawk_pgwr_mngr u_pgwr_mngr (
      .clk_i     (clk_i),
      .reset     (reset),
      .att_upd   (att_upd),
      .upd_busy  (upd_busy),
      .init_done (init_done),
      .wr_req    (wr_req),
      .wr_rsp    (wr_rsp)
   );

   hawk_pgrd_mngr u_pgrd_mngr (
      .clk_i     (clk_i),
      .reset     (reset),
      .init_done (init_done),
      .cpu_req   (cpu_req),
      .cpu_rsp   (cpu_rsp),
      .rd_req    (rd_req),
      .rd_rsp    (rd_rsp)
   );

   // writer on m0 so att updates win
   hawk_wb_arb u_wb_arb (
      .clk_i   (clk_i),
      .reset   (reset),
      .m0_req  (wr_req),
      .m0_rsp  (wr_rsp),
      .m1_req  (rd_req),
      .m1_rsp  (rd_rsp),
      .out_req (mem_req),
      .out_rsp (mem_rsp)
   );

endmodule

//--- logic/hawk_wb_arb.sv
`timescale 1ns/10ps

module hawk_wb_arb import hawk_pkg::*; (
   input  logic    clk_i,
   input  logic    reset,
   input  wb_req_t m0_req,
   output wb_rsp_t m0_rsp,
   input  wb_req_t m1_req,
   output wb_rsp_t m1_rsp,
   output wb_req_t out_req,
   input  wb_rsp_t out_rsp
);

   typedef enum logic [1:0] {
      GNT_NONE,
      GNT_M0,
      GNT_M1
   } gnt_t;

   gnt_t gnt_q;
   logic bus_cyc;

   // cyc of whoever holds the bus
   always_comb begin
      case (gnt_q)
         GNT_M0:  bus_cyc = m0_req.cyc;
         GNT_M1:  bus_cyc = m1_req.cyc;
         default: bus_cyc = 1'b0;
      endcase
   end

   // m0 first, grant held for the whole cyc
   always_ff @(posedge clk_i) begin
      if (reset) begin
         gnt_q <= GNT_NONE;
      end else if (!bus_cyc) begin
         if (m0_req.cyc)
            gnt_q <= GNT_M0;
         else if (m1_req.cyc)
            gnt_q <= GNT_M1;
         else
            gnt_q <= GNT_NONE;
      end
   end

   always_comb begin
      case (gnt_q)
         GNT_M0:  out_req = m0_req;
         GNT_M1:  out_req = m1_req;
         default: out_req = '0;
      endcase
   end

   // losing master just sees no ack
   always_comb begin
      m0_rsp.ack = out_rsp.ack & (gnt_q == GNT_M0);
      m0_rsp.dat = (gnt_q == GNT_M0) ? out_rsp.dat : '0;
      m1_rsp.ack = out_rsp.ack & (gnt_q == GNT_M1);
      m1_rsp.dat = (gnt_q == GNT_M1) ? out_rsp.dat : '0;
   end

endmodule

//--- logic/hawk_pgrd_mngr.sv
`timescale 1ns/10ps

module hawk_pgrd_mngr import hawk_pkg::*; (
   input  logic    clk_i,
   input  logic    reset,
   input  logic    init_done,
   input  wb_req_t cpu_req,
   output wb_rsp_t cpu_rsp,
   output wb_req_t rd_req,
   input  wb_rsp_t rd_rsp
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_LKUP,
      S_ACC
   } pgrd_state_t;

   pgrd_state_t        state_q;
   logic [PPAGE_W-1:0] ppage_q;
   logic [VPAGE_W-1:0] cpu_vpage;
   logic [OFFS_W-1:0]  cpu_offs;
   logic               cpu_access;

   ////////////////////////////////////////////////////////////////////////////
   // cpu address split
   ////////////////////////////////////////////////////////////////////////////

   assign cpu_vpage  = cpu_req.adr[OFFS_W +: VPAGE_W];
   assign cpu_offs   = cpu_req.adr[OFFS_W-1:0];
   assign cpu_access = cpu_req.cyc & cpu_req.stb;

   ////////////////////////////////////////////////////////////////////////////
   // lookup then translated access
   ////////////////////////////////////////////////////////////////////////////

   // cpu waits here until the att is filled
   always_ff @(posedge clk_i) begin
      if (reset) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (cpu_access && init_done)
                  state_q <= S_LKUP;
            end
            S_LKUP: begin
               if (rd_rsp.ack)
                  state_q <= S_ACC;
            end
            default: begin
               if (rd_rsp.ack)
                  state_q <= S_IDLE;
            end
         endcase
      end
   end

   // physical page from the att entry
   always_ff @(posedge clk_i) begin
      if (state_q == S_LKUP && rd_rsp.ack)
         ppage_q <= rd_rsp.dat[PPAGE_W-1:0];
   end

   // cyc stays up from the lookup into the access
   always_comb begin
      rd_req.cyc = (state_q != S_IDLE);
      rd_req.stb = (state_q != S_IDLE);
      if (state_q == S_ACC) begin
         rd_req.we  = cpu_req.we;
         rd_req.adr = {ppage_q, cpu_offs};
         rd_req.dat = cpu_req.dat;
         rd_req.sel = cpu_req.sel;
      end else begin
         rd_req.we  = 1'b0;
         rd_req.adr = ATT_BASE + ADDR_W'(cpu_vpage);
         rd_req.dat = '0;
         rd_req.sel = {SEL_W{1'b1}};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // cpu response
   ////////////////////////////////////////////////////////////////////////////

   // only the second ack goes back, the lookup stalls the cpu
   always_comb begin
      cpu_rsp.ack = (state_q == S_ACC) & rd_rsp.ack;
      cpu_rsp.dat = (state_q == S_ACC) ? rd_rsp.dat : '0;
   end

endmodule

//--- logic/hawk_pgwr_mngr.sv
`timescale 1ns/10ps

module hawk_pgwr_mngr import hawk_pkg::*; (
   input  logic     clk_i,
   input  logic     reset,
   input  att_upd_t att_upd,
   output logic     upd_busy,
   output logic     init_done,
   output wb_req_t  wr_req,
   input  wb_rsp_t  wr_rsp
);

   typedef enum logic [1:0] {
      S_INIT,
      S_IDLE,
      S_UPD
   } pgwr_state_t;

   pgwr_state_t        state_q;
   logic [VPAGE_W-1:0] ent_q;
   logic [VPAGE_W-1:0] upd_vpage_q;
   logic [PPAGE_W-1:0] upd_ppage_q;
   logic [VPAGE_W-1:0] cur_vpage;
   logic [PPAGE_W-1:0] cur_ppage;

   // init walk first, then one update at a time
   always_ff @(posedge clk_i) begin
      if (reset) begin
         state_q   <= S_INIT;
         ent_q     <= '0;
         init_done <= 1'b0;
      end else begin
         case (state_q)
            S_INIT: begin
               if (wr_rsp.ack) begin
                  if (ent_q == VPAGE_W'(ATT_ENTRIES - 1)) begin
                     state_q   <= S_IDLE;
                     init_done <= 1'b1;
                  end else begin
                     ent_q <= ent_q + 1'b1;
                  end
               end
            end
            S_IDLE: begin
               if (att_upd.valid)
                  state_q <= S_UPD;
            end
            default: begin
               if (wr_rsp.ack)
                  state_q <= S_IDLE;
            end
         endcase
      end
   end

   // update payload, taken on acceptance
   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && att_upd.valid) begin
         upd_vpage_q <= att_upd.vpage;
         upd_ppage_q <= att_upd.ppage;
      end
   end

   // busy through init and any update still waiting for its ack
   assign upd_busy = (state_q != S_IDLE);

   always_comb begin
      cur_vpage  = (state_q == S_INIT) ? ent_q : upd_vpage_q;
      cur_ppage  = (state_q == S_INIT) ? DATA_BASE_PAGE + PPAGE_W'(ent_q) : upd_ppage_q;
      wr_req.cyc = (state_q != S_IDLE);
      wr_req.stb = (state_q != S_IDLE);
      wr_req.we  = 1'b1;
      wr_req.adr = ATT_BASE + ADDR_W'(cur_vpage);
      wr_req.dat = {{(DATA_W - PPAGE_W){1'b0}}, cur_ppage};
      wr_req.sel = {SEL_W{1'b1}};
   end

endmodule

//--- logic/hawk_pkg.sv
package hawk_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // bus and address widths
   ////////////////////////////////////////////////////////////////////////////

   localparam int ADDR_W  = 16;
   localparam int DATA_W  = 32;
   localparam int SEL_W   = DATA_W / 8;

   // word offset inside a page, 16 words per page
   localparam int OFFS_W  = 4;

   // virtual page number, one att entry each
   localparam int VPAGE_W     = 4;
   localparam int ATT_ENTRIES = 1 << VPAGE_W;

   // physical page number fills the rest of the word address
   localparam int PPAGE_W = ADDR_W - OFFS_W;

   ////////////////////////////////////////////////////////////////////////////
   // address map
   ////////////////////////////////////////////////////////////////////////////

   // att entry v sits at ATT_BASE + v
   localparam logic [ADDR_W-1:0]  ATT_BASE       = 16'h0000;

   // default mapping after init, vpage v -> DATA_BASE_PAGE + v
   localparam logic [PPAGE_W-1:0] DATA_BASE_PAGE = 12'h010;

   ////////////////////////////////////////////////////////////////////////////
   // wishbone classic and att update bundles
   ////////////////////////////////////////////////////////////////////////////

   // master side
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
   } wb_req_t;

   // slave side
   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

   // rewrite of a single att entry
   typedef struct packed {
      logic               valid;
      logic [VPAGE_W-1:0] vpage;
      logic [PPAGE_W-1:0] ppage;
   } att_upd_t;

endpackage
